/* logic/rx_link_pkg.sv */
// Link layout package for the memory-mapped packet receiver
// Channel framing, packet fields, grant codes and payload types

package rx_link_pkg;

  //////////////////////////////////////////////////////////////////////
  // PHY channel layout
  //////////////////////////////////////////////////////////////////////

  // Raw word per channel, half rate
  localparam int ch_width      = 80;

  // Usable bits once strobe and both markers are removed
  localparam int ch_data_width = 77;

  // Framing positions inside the raw word
  localparam int strobe_loc    = 1;
  localparam int marker_lo_loc = 39;
  localparam int marker_hi_loc = 79;

  //////////////////////////////////////////////////////////////////////
  // Packet layout
  //////////////////////////////////////////////////////////////////////

  localparam int packet_width    = 150;

  // Channel 0 usable bit 0 is the grant code, bits 1 up are packet
  localparam int ch0_packet_bits = 76;

  // Channel 1 starts with the rest of the packet
  localparam int ch1_packet_bits = 74;

  // Returned credits in channel 1, ar then aw then w
  localparam int credit_base     = 74;

  // Logic link payload widths, push bit sits right above the data
  localparam int r_data_width    = 135;
  localparam int b_data_width    = 6;

  //////////////////////////////////////////////////////////////////////
  // Grant codes
  //////////////////////////////////////////////////////////////////////

  // Write response owns the packet
  localparam logic grant_b = 1'b0;
  // Read response owns the packet
  localparam logic grant_r = 1'b1;

  //////////////////////////////////////////////////////////////////////
  // Types
  //////////////////////////////////////////////////////////////////////

  typedef logic [ch_width-1:0]      phy_word_t;
  typedef logic [ch_data_width-1:0] ch_data_t;
  typedef logic [packet_width-1:0]  packet_t;
  typedef logic [r_data_width-1:0]  r_data_t;
  typedef logic [b_data_width-1:0]  b_data_t;

endpackage

/* logic/rx_channel_deframer.sv */
// Channel deframer for one PHY word
// Drops strobe and marker bits, optional boundary register on the result

module rx_channel_deframer #(
  // 1 adds a boundary flop for timing, 0 leaves the path combinational
  parameter bit reg_phy = 1'b1
) (
  input  logic                    clk_rd,
  input  logic                    rst_rd_n,
  input  rx_link_pkg::phy_word_t  phy_word,
  output rx_link_pkg::ch_data_t   ch_data
);

  //////////////////////////////////////////////////////////////////////
  // Framing removal
  //////////////////////////////////////////////////////////////////////

  // Raw word map
  //   [0]       data
  //   [1]       strobe
  //   [38:2]    data
  //   [39]      lower marker
  //   [78:40]   data
  //   [79]      upper marker
  // Data bits keep their order, lowest raw bit lands in usable bit 0

  rx_link_pkg::ch_data_t ch_data_comb;

  assign ch_data_comb = {
    // Between the two markers
    phy_word[rx_link_pkg::marker_hi_loc-1 : rx_link_pkg::marker_lo_loc+1],
    // Between strobe and lower marker
    phy_word[rx_link_pkg::marker_lo_loc-1 : rx_link_pkg::strobe_loc+1],
    // Below the strobe
    phy_word[rx_link_pkg::strobe_loc-1 : 0]
  };

  //////////////////////////////////////////////////////////////////////
  // Boundary register
  //////////////////////////////////////////////////////////////////////

  generate
    if (reg_phy)
    begin : g_boundary_reg
      rx_link_pkg::ch_data_t ch_data_q;

      // Only the usable bits are kept, framing never reaches the flop
      always_ff @(posedge clk_rd or negedge rst_rd_n)
      begin
        if (!rst_rd_n)
        begin
          ch_data_q <= '0;
        end
        else
        begin
          ch_data_q <= ch_data_comb;
        end
      end

      assign ch_data = ch_data_q;
    end
    else
    begin : g_no_boundary_reg
      // Same cycle as the PHY word
      assign ch_data = ch_data_comb;
    end
  endgenerate

endmodule

/* logic/rx_packet_unpacker.sv */
// Packet unpacker for two deframed channel words
// Grant, packet and credit extraction plus r and b logic link decode

module rx_packet_unpacker (
  input  rx_link_pkg::ch_data_t  ch0_data,
  input  rx_link_pkg::ch_data_t  ch1_data,

  // Read response link
  output rx_link_pkg::r_data_t   rx_r_data,
  output logic                   rx_r_pushbit,
  output logic                   rx_r_push_ovrd,

  // Write response link
  output rx_link_pkg::b_data_t   rx_b_data,
  output logic                   rx_b_pushbit,
  output logic                   rx_b_push_ovrd,

  // Credits returned by the far side
  output logic                   rx_ar_credit,
  output logic                   rx_aw_credit,
  output logic                   rx_w_credit
);

  //////////////////////////////////////////////////////////////////////
  // Channel split
  //////////////////////////////////////////////////////////////////////

  logic                  grant_code;
  rx_link_pkg::packet_t  packet;

  // Channel 0 carries the grant code first
  assign grant_code = ch0_data[0];

  // Low packet bits follow the grant in channel 0,
  // channel 1 holds the upper part
  assign packet = {
    ch1_data[rx_link_pkg::ch1_packet_bits-1 : 0],
    ch0_data[rx_link_pkg::ch0_packet_bits : 1]
  };

  // Credits sit after the packet bits in channel 1
  assign rx_ar_credit = ch1_data[rx_link_pkg::credit_base];
  assign rx_aw_credit = ch1_data[rx_link_pkg::credit_base + 1];
  assign rx_w_credit  = ch1_data[rx_link_pkg::credit_base + 2];

  //////////////////////////////////////////////////////////////////////
  // Grant decode
  //////////////////////////////////////////////////////////////////////

  logic grant_is_r;
  logic grant_is_b;

  assign grant_is_r = (grant_code == rx_link_pkg::grant_r);
  assign grant_is_b = (grant_code == rx_link_pkg::grant_b);

  // Override is high on every cycle the link does not own
  assign rx_r_push_ovrd = !grant_is_r;
  assign rx_b_push_ovrd = !grant_is_b;

  // Push bit only counts when the packet belongs to that link
  assign rx_r_pushbit = grant_is_r && packet[rx_link_pkg::r_data_width];
  assign rx_b_pushbit = grant_is_b && packet[rx_link_pkg::b_data_width];

  //////////////////////////////////////////////////////////////////////
  // Payload
  //////////////////////////////////////////////////////////////////////

  // Both links see the low packet bits on every cycle,
  // the overrides decide which one is taken
  assign rx_r_data = packet[rx_link_pkg::r_data_width-1 : 0];
  assign rx_b_data = packet[rx_link_pkg::b_data_width-1 : 0];

endmodule

/* logic/rx_mem_master_top.sv */
// Receive top for the memory-mapped link
// Two channel deframers with boundary flops feeding the packet unpacker

module rx_mem_master_top (
  input  logic                    clk_rd,
  input  logic                    rst_rd_n,

  // PHY channel words
  input  rx_link_pkg::phy_word_t  rx_phy0,
  input  rx_link_pkg::phy_word_t  rx_phy1,

  // Read response link
  output rx_link_pkg::r_data_t    rx_r_data,
  output logic                    rx_r_pushbit,
  output logic                    rx_r_push_ovrd,

  // Write response link
  output rx_link_pkg::b_data_t    rx_b_data,
  output logic                    rx_b_pushbit,
  output logic                    rx_b_push_ovrd,

  // Returned credits
  output logic                    rx_ar_credit,
  output logic                    rx_aw_credit,
  output logic                    rx_w_credit
);

  //////////////////////////////////////////////////////////////////////
  // Deframing
  //////////////////////////////////////////////////////////////////////

  rx_link_pkg::ch_data_t ch0_data;
  rx_link_pkg::ch_data_t ch1_data;

  // Boundary flops on, so outputs follow the PHY by one clk_rd cycle
  rx_channel_deframer #(
    .reg_phy  (1'b1)
  ) u_deframer0 (
    .clk_rd   (clk_rd),
    .rst_rd_n (rst_rd_n),
    .phy_word (rx_phy0),
    .ch_data  (ch0_data)
  );

  rx_channel_deframer #(
    .reg_phy  (1'b1)
  ) u_deframer1 (
    .clk_rd   (clk_rd),
    .rst_rd_n (rst_rd_n),
    .phy_word (rx_phy1),
    .ch_data  (ch1_data)
  );

  //////////////////////////////////////////////////////////////////////
  // Unpacking
  //////////////////////////////////////////////////////////////////////

  // Purely combinational after the boundary flops
  rx_packet_unpacker u_unpacker (
    .ch0_data       (ch0_data),
    .ch1_data       (ch1_data),
    .rx_r_data      (rx_r_data),
    .rx_r_pushbit   (rx_r_pushbit),
    .rx_r_push_ovrd (rx_r_push_ovrd),
    .rx_b_data      (rx_b_data),
    .rx_b_pushbit   (rx_b_pushbit),
    .rx_b_push_ovrd (rx_b_push_ovrd),
    .rx_ar_credit   (rx_ar_credit),
    .rx_aw_credit   (rx_aw_credit),
    .rx_w_credit    (rx_w_credit)
  );

endmodule

/* tests/rx_tb_model.svh */
// Reference model for the receive link testbench
// Field records, PHY word builders and output prediction

`ifndef RX_TB_MODEL_SVH
`define RX_TB_MODEL_SVH

// Link content carried by one word pair
typedef struct packed {
  logic                 grant;
  rx_link_pkg::packet_t packet;
  logic                 ar_credit;
  logic                 aw_credit;
  logic                 w_credit;
} link_fields_t;

// Expected value of every link output
typedef struct packed {
  rx_link_pkg::r_data_t r_data;
  logic                 r_pushbit;
  logic                 r_push_ovrd;
  rx_link_pkg::b_data_t b_data;
  logic                 b_pushbit;
  logic                 b_push_ovrd;
  logic                 ar_credit;
  logic                 aw_credit;
  logic                 w_credit;
} link_out_t;

//////////////////////////////////////////////////////////////////////
// PHY word construction
//////////////////////////////////////////////////////////////////////

// Framing bits given as {marker_hi, marker_lo, strobe}
function automatic rx_link_pkg::phy_word_t frame_channel(
  input rx_link_pkg::ch_data_t usable,
  input logic [2:0]            framing
);
  rx_link_pkg::phy_word_t word;
  int                     k;
  word = '0;
  k = 0;
  for (int pos = 0; pos < rx_link_pkg::ch_width; pos++)
  begin
    if (pos == rx_link_pkg::strobe_loc)
      word[pos] = framing[0];
    else if (pos == rx_link_pkg::marker_lo_loc)
      word[pos] = framing[1];
    else if (pos == rx_link_pkg::marker_hi_loc)
      word[pos] = framing[2];
    else
    begin
      // Usable bits fill the free slots in ascending order
      word[pos] = usable[k];
      k++;
    end
  end
  return word;
endfunction

// Channel 0 carries the grant code and the low packet bits
function automatic rx_link_pkg::phy_word_t build_phy0(
  input link_fields_t f,
  input logic [2:0]   framing
);
  rx_link_pkg::ch_data_t usable;
  usable = '0;
  usable[0] = f.grant;
  for (int i = 0; i < rx_link_pkg::ch0_packet_bits; i++)
    usable[i + 1] = f.packet[i];
  return frame_channel(usable, framing);
endfunction

// Channel 1 carries the high packet bits and the credits
function automatic rx_link_pkg::phy_word_t build_phy1(
  input link_fields_t f,
  input logic [2:0]   framing
);
  rx_link_pkg::ch_data_t usable;
  usable = '0;
  for (int i = 0; i < rx_link_pkg::ch1_packet_bits; i++)
    usable[i] = f.packet[rx_link_pkg::ch0_packet_bits + i];
  usable[rx_link_pkg::credit_base]     = f.ar_credit;
  usable[rx_link_pkg::credit_base + 1] = f.aw_credit;
  usable[rx_link_pkg::credit_base + 2] = f.w_credit;
  return frame_channel(usable, framing);
endfunction

//////////////////////////////////////////////////////////////////////
// Output prediction
//////////////////////////////////////////////////////////////////////

function automatic link_out_t predict_outputs(input link_fields_t f);
  link_out_t exp;
  exp = '0;
  exp.r_data    = f.packet[rx_link_pkg::r_data_width-1:0];
  exp.b_data    = f.packet[rx_link_pkg::b_data_width-1:0];
  exp.ar_credit = f.ar_credit;
  exp.aw_credit = f.aw_credit;
  exp.w_credit  = f.w_credit;
  if (f.grant == rx_link_pkg::grant_b)
  begin
    exp.b_push_ovrd = 1'b0;
    exp.r_push_ovrd = 1'b1;
    exp.r_pushbit   = 1'b0;
    exp.b_pushbit   = f.packet[6];
  end
  else
  begin
    exp.r_push_ovrd = 1'b0;
    exp.b_push_ovrd = 1'b1;
    exp.b_pushbit   = 1'b0;
    exp.r_pushbit   = f.packet[135];
  end
  return exp;
endfunction

// Zeroed boundary flops decode as a b grant
function automatic link_out_t reset_expectation();
  link_out_t exp;
  exp = '0;
  exp.r_push_ovrd = 1'b1;
  return exp;
endfunction

`endif

/* tests/rx_tb.sv */
// Testbench for the receive link top level
// Random word pairs checked against a reference model one cycle later

module rx_tb;

  `include "rx_tb_model.svh"

  localparam int reset_cycles    = 8;
  localparam int release_timeout = 4;
  localparam int response_words  = 300;
  localparam int framing_pairs   = 200;
  localparam int stream_words    = 2000;

  logic                   clk_rd = 1'b0;
  logic                   rst_rd_n;
  rx_link_pkg::phy_word_t rx_phy0;
  rx_link_pkg::phy_word_t rx_phy1;

  rx_link_pkg::r_data_t   rx_r_data;
  logic                   rx_r_pushbit;
  logic                   rx_r_push_ovrd;
  rx_link_pkg::b_data_t   rx_b_data;
  logic                   rx_b_pushbit;
  logic                   rx_b_push_ovrd;
  logic                   rx_ar_credit;
  logic                   rx_aw_credit;
  logic                   rx_w_credit;

  integer    seed;

  // One-deep expectation pipe for the boundary register stage
  link_out_t pending;
  string     pending_name;

  rx_mem_master_top dut (
    .clk_rd         (clk_rd),
    .rst_rd_n       (rst_rd_n),
    .rx_phy0        (rx_phy0),
    .rx_phy1        (rx_phy1),
    .rx_r_data      (rx_r_data),
    .rx_r_pushbit   (rx_r_pushbit),
    .rx_r_push_ovrd (rx_r_push_ovrd),
    .rx_b_data      (rx_b_data),
    .rx_b_pushbit   (rx_b_pushbit),
    .rx_b_push_ovrd (rx_b_push_ovrd),
    .rx_ar_credit   (rx_ar_credit),
    .rx_aw_credit   (rx_aw_credit),
    .rx_w_credit    (rx_w_credit)
  );

  always #10 clk_rd = ~clk_rd;

  //////////////////////////////////////////////////////////////////////
  // Reporting and checks
  //////////////////////////////////////////////////////////////////////

  task automatic report_mismatch(
    input string test_name,
    input string signal_name,
    input string expected,
    input string actual
  );
    $display("Fail %s %s expected %s actual %s", test_name, signal_name, expected, actual);
    $display("ERRORS FOUND");
    $fatal(1, "Output mismatch");
  endtask

  task automatic report_failure(input string what);
    $display("%s", what);
    $display("ERRORS FOUND");
    $fatal(1, "Run stopped");
  endtask

  task automatic check_outputs(input string test_name, input link_out_t exp);
    assert (rx_r_data === exp.r_data)
    else
      report_mismatch(test_name, "rx_r_data",
                      $sformatf("%h", exp.r_data), $sformatf("%h", rx_r_data));
    assert (rx_r_pushbit === exp.r_pushbit)
    else
      report_mismatch(test_name, "rx_r_pushbit",
                      $sformatf("%b", exp.r_pushbit), $sformatf("%b", rx_r_pushbit));
    assert (rx_r_push_ovrd === exp.r_push_ovrd)
    else
      report_mismatch(test_name, "rx_r_push_ovrd",
                      $sformatf("%b", exp.r_push_ovrd), $sformatf("%b", rx_r_push_ovrd));
    assert (rx_b_data === exp.b_data)
    else
      report_mismatch(test_name, "rx_b_data",
                      $sformatf("%h", exp.b_data), $sformatf("%h", rx_b_data));
    assert (rx_b_pushbit === exp.b_pushbit)
    else
      report_mismatch(test_name, "rx_b_pushbit",
                      $sformatf("%b", exp.b_pushbit), $sformatf("%b", rx_b_pushbit));
    assert (rx_b_push_ovrd === exp.b_push_ovrd)
    else
      report_mismatch(test_name, "rx_b_push_ovrd",
                      $sformatf("%b", exp.b_push_ovrd), $sformatf("%b", rx_b_push_ovrd));
    assert (rx_ar_credit === exp.ar_credit)
    else
      report_mismatch(test_name, "rx_ar_credit",
                      $sformatf("%b", exp.ar_credit), $sformatf("%b", rx_ar_credit));
    assert (rx_aw_credit === exp.aw_credit)
    else
      report_mismatch(test_name, "rx_aw_credit",
                      $sformatf("%b", exp.aw_credit), $sformatf("%b", rx_aw_credit));
    assert (rx_w_credit === exp.w_credit)
    else
      report_mismatch(test_name, "rx_w_credit",
                      $sformatf("%b", exp.w_credit), $sformatf("%b", rx_w_credit));
  endtask

  //////////////////////////////////////////////////////////////////////
  // Stimulus
  //////////////////////////////////////////////////////////////////////

  task automatic draw_fields(output link_fields_t f);
    logic [159:0] bits;
    logic [31:0]  r;
    bits = '0;
    for (int w = 0; w < 5; w++)
    begin
      r = $random(seed);
      bits = {r, bits[159:32]};
    end
    f.packet = bits[rx_link_pkg::packet_width-1:0];
    r = $random(seed);
    f.grant     = r[0];
    f.ar_credit = r[1];
    f.aw_credit = r[2];
    f.w_credit  = r[3];
  endtask

  task automatic draw_framing(output logic [2:0] framing);
    logic [31:0] r;
    r = $random(seed);
    framing = r[2:0];
  endtask

  // Called on a falling edge and returns on the next one
  task automatic run_cycle(
    input string        test_name,
    input link_fields_t f,
    input logic [2:0]   framing0,
    input logic [2:0]   framing1
  );
    check_outputs(pending_name, pending);
    rx_phy0 = build_phy0(f, framing0);
    rx_phy1 = build_phy1(f, framing1);
    pending = predict_outputs(f);
    pending_name = test_name;
    @(negedge clk_rd);
  endtask

  task automatic wait_reset_release();
    int waited;
    waited = 0;
    while (rst_rd_n !== 1'b1)
    begin
      if (waited >= release_timeout)
        report_failure("Reset was not released in time");
      @(negedge clk_rd);
      waited++;
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // Test sequence
  //////////////////////////////////////////////////////////////////////

  initial
  begin
    link_fields_t f;
    logic [2:0]   fr0;
    logic [2:0]   fr1;
    seed = 32'h7175247e;
    rst_rd_n = 1'b0;
    rx_phy0 = '0;
    rx_phy1 = '0;
    pending = reset_expectation();
    pending_name = "reset";

    // Words driven during reset never reach the outputs
    for (int cycle = 0; cycle < reset_cycles; cycle++)
    begin
      @(negedge clk_rd);
      check_outputs("reset", reset_expectation());
      draw_fields(f);
      draw_framing(fr0);
      draw_framing(fr1);
      rx_phy0 = build_phy0(f, fr0);
      rx_phy1 = build_phy1(f, fr1);
    end
    rst_rd_n = 1'b1;
    wait_reset_release();
    pending_name = "reset_exit";

    // Write response cycles
    for (int i = 0; i < response_words; i++)
    begin
      draw_fields(f);
      f.grant = rx_link_pkg::grant_b;
      draw_framing(fr0);
      draw_framing(fr1);
      run_cycle("write_response", f, fr0, fr1);
    end

    // Read response cycles
    for (int i = 0; i < response_words; i++)
    begin
      draw_fields(f);
      f.grant = rx_link_pkg::grant_r;
      draw_framing(fr0);
      draw_framing(fr1);
      run_cycle("read_response", f, fr0, fr1);
    end

    // Every credit pattern under both grants
    for (int combo = 0; combo < 16; combo++)
    begin
      draw_fields(f);
      f.grant     = combo[3];
      f.ar_credit = combo[2];
      f.aw_credit = combo[1];
      f.w_credit  = combo[0];
      draw_framing(fr0);
      draw_framing(fr1);
      run_cycle("credits", f, fr0, fr1);
    end

    // Same fields twice with every framing bit flipped the second time
    for (int i = 0; i < framing_pairs; i++)
    begin
      draw_fields(f);
      draw_framing(fr0);
      draw_framing(fr1);
      run_cycle("framing", f, fr0, fr1);
      run_cycle("framing", f, ~fr0, ~fr1);
    end

    // Back to back pairs with mixed grants
    for (int i = 0; i < stream_words; i++)
    begin
      draw_fields(f);
      draw_framing(fr0);
      draw_framing(fr1);
      run_cycle("streaming", f, fr0, fr1);
    end

    // Last pair still in flight
    check_outputs(pending_name, pending);

    $display("NO ERRORS");
    $finish;
  end

endmodule

/* sources.f */
+incdir+tests
logic/rx_link_pkg.sv
logic/rx_channel_deframer.sv
logic/rx_packet_unpacker.sv
logic/rx_mem_master_top.sv
tests/rx_tb.sv

/* Makefile */
# Verilator build and run of the receive link testbench

TOOL     := verilator
FLAGS    := --binary --assert
TOP      := rx_tb
FILELIST := sources.f

OBJ_DIR  := obj_dir
BIN      := $(OBJ_DIR)/V$(TOP)
LOG      := sim.log
PASS_MSG := NO ERRORS

# Sources and headers come from the file list and the test folder
SOURCES  := $(filter-out +%,$(shell cat $(FILELIST)))
HEADERS  := $(wildcard tests/*.svh)

.PHONY: all run check clean

all: run

# Rebuilt only when a source, a header or the file list changes
$(BIN): $(FILELIST) $(SOURCES) $(HEADERS)
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: $(BIN)
	-./$(BIN) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "^$(PASS_MSG)$$" $(LOG)

# Judges the log of the last run
check:
	@grep -q "^$(PASS_MSG)$$" $(LOG) && echo "Simulation passed" || \
		(echo "Simulation failed"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
